/* flist.f */
+incdir+logic
logic/rv_isa_pkg.sv
logic/exec_pkg.sv
logic/alu.sv
logic/arith.sv
logic/regfile.sv
logic/exec_top.sv
test/exec_tb.sv

/* logic/alu.sv */
/* Combinational RV32I ALU.
 * Applies the function on func_i to the two operands, no state.
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module alu (
    input  rv_isa_pkg::word_t   op_a_i,
    input  rv_isa_pkg::word_t   op_b_i,
    input  exec_pkg::alu_func_t func_i,
    output rv_isa_pkg::word_t   result_o
);
    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];  // Shifts only look at the low 5 bits.

    always_comb begin
        case (func_i)
            `ALU_OP_ADD: begin
                result_o = op_a_i + op_b_i;
            end
            `ALU_OP_SUB: begin
                result_o = op_a_i - op_b_i;
            end
            `ALU_OP_SLL: begin
                result_o = op_a_i << shamt;
            end
            `ALU_OP_SLT: begin
                result_o = {{(`XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            end
            `ALU_OP_SLTU: begin
                result_o = {{(`XLEN-1){1'b0}}, op_a_i < op_b_i};
            end
            `ALU_OP_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            `ALU_OP_SRL: begin
                result_o = op_a_i >> shamt;
            end
            `ALU_OP_SRA: begin
                result_o = $signed(op_a_i) >>> shamt;
            end
            `ALU_OP_OR: begin
                result_o = op_a_i | op_b_i;
            end
            `ALU_OP_AND: begin
                result_o = op_a_i & op_b_i;
            end
            `ALU_OP_PASS_B: begin
                result_o = op_b_i;
            end
            default: begin
                result_o = '0;  // Unused codes.
            end
        endcase
    end

endmodule

/* logic/arith.sv */
/* Arithmetic unit: decodes one issued instruction, picks ALU operands and function,
 * and registers the write-back one cycle after issue.
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module arith (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  exec_pkg::issue_t  issue_i,
    input  rv_isa_pkg::word_t rs1_val_i,
    input  rv_isa_pkg::word_t rs2_val_i,
    output exec_pkg::wb_t     wb_o
);
    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::funct7_t   funct7;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     imm_i;
    rv_isa_pkg::word_t     imm_u;
    rv_isa_pkg::word_t     shamt;

    rv_isa_pkg::word_t     alu_op_a;
    rv_isa_pkg::word_t     alu_op_b;
    exec_pkg::alu_func_t   alu_func;
    rv_isa_pkg::word_t     alu_result;
    logic                  illegal;

    logic                  valid_q;
    logic                  illegal_q;
    rv_isa_pkg::reg_addr_t rd_q;
    rv_isa_pkg::word_t     value_q;

    assign opcode = issue_i.inst[6:0];
    assign funct3 = issue_i.inst[14:12];
    assign funct7 = issue_i.inst[31:25];
    assign rd     = issue_i.inst[11:7];

    assign imm_i = {{(`XLEN-12){issue_i.inst[31]}}, issue_i.inst[31:20]};
    assign imm_u = {issue_i.inst[31:12], 12'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, issue_i.inst[24:20]};

    alu alu_i (
        .op_a_i   (alu_op_a),
        .op_b_i   (alu_op_b),
        .func_i   (alu_func),
        .result_o (alu_result)
    );

    // Operand and function select.
    always_comb begin
        alu_op_a = rs1_val_i;
        alu_op_b = rs2_val_i;
        alu_func = `ALU_OP_ADD;
        illegal  = 1'b0;
        case (opcode)
            `OP_OP: begin
                // Only ADD/SUB and SRL/SRA have an alternate funct7.
                illegal = !((funct7 == `FUNCT7_BASE) ||
                            ((funct7 == `FUNCT7_ALT) &&
                             ((funct3 == `FUNCT3_ADD_SUB) || (funct3 == `FUNCT3_SR))));
                case (funct3)
                    `FUNCT3_ADD_SUB: begin
                        alu_func = (funct7 == `FUNCT7_ALT) ? `ALU_OP_SUB : `ALU_OP_ADD;
                    end
                    `FUNCT3_SLL:  alu_func = `ALU_OP_SLL;
                    `FUNCT3_SLT:  alu_func = `ALU_OP_SLT;
                    `FUNCT3_SLTU: alu_func = `ALU_OP_SLTU;
                    `FUNCT3_XOR:  alu_func = `ALU_OP_XOR;
                    `FUNCT3_SR: begin
                        alu_func = (funct7 == `FUNCT7_ALT) ? `ALU_OP_SRA : `ALU_OP_SRL;
                    end
                    `FUNCT3_OR:   alu_func = `ALU_OP_OR;
                    default:      alu_func = `ALU_OP_AND;
                endcase
            end
            `OP_OP_IMM: begin
                alu_op_b = imm_i;
                case (funct3)
                    `FUNCT3_ADD_SUB: alu_func = `ALU_OP_ADD;  // ADDI, no SUBI.
                    `FUNCT3_SLL: begin
                        alu_op_b = shamt;
                        alu_func = `ALU_OP_SLL;
                        illegal  = (funct7 != `FUNCT7_BASE);
                    end
                    `FUNCT3_SLT:  alu_func = `ALU_OP_SLT;
                    `FUNCT3_SLTU: alu_func = `ALU_OP_SLTU;
                    `FUNCT3_XOR:  alu_func = `ALU_OP_XOR;
                    `FUNCT3_SR: begin
                        alu_op_b = shamt;
                        alu_func = (funct7 == `FUNCT7_ALT) ? `ALU_OP_SRA : `ALU_OP_SRL;
                        illegal  = (funct7 != `FUNCT7_BASE) && (funct7 != `FUNCT7_ALT);
                    end
                    `FUNCT3_OR:   alu_func = `ALU_OP_OR;
                    default:      alu_func = `ALU_OP_AND;
                endcase
            end
            `OP_LUI: begin
                alu_op_b = imm_u;
                alu_func = `ALU_OP_PASS_B;
            end
            `OP_AUIPC: begin
                alu_op_a = issue_i.pc;
                alu_op_b = imm_u;
            end
            `OP_JAL, `OP_JALR: begin
                // Link value only, the target is computed elsewhere.
                alu_op_a = issue_i.pc;
                alu_op_b = rv_isa_pkg::word_t'(4);
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= issue_i.valid;  // One pulse per accepted issue.
            illegal_q <= issue_i.valid & illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i.valid) begin
            rd_q    <= rd;
            value_q <= illegal ? '0 : alu_result;
        end
    end

    assign wb_o = '{valid: valid_q, illegal: illegal_q, rd: rd_q, value: value_q};

endmodule

/* logic/exec_pkg.sv */
/* Types of the execute path: ALU function code and the issue and write-back ports.
 * Referenced by scoped name from the slice modules and the testbench.
 */
package exec_pkg;

    // Function select of the ALU, one of the ALU_OP codes.
    typedef logic [3:0] alu_func_t;

    // One instruction offered to the slice.
    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t pc;
        rv_isa_pkg::inst_t inst;
    } issue_t;

    // One result leaving the slice, also fed back to the register file.
    typedef struct packed {
        logic                  valid;
        logic                  illegal;  // Unhandled instruction, value is zero.
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     value;
    } wb_t;

endpackage

/* logic/exec_top.sv */
/* Top of the RV32I execute slice.
 * Register reads from the issued instruction feed the arithmetic unit,
 * whose write-back leaves the slice and returns to the register file.
 */
`timescale 1ns/10ps

module exec_top (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  exec_pkg::issue_t issue_i,
    output exec_pkg::wb_t    wb_o
);
    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::word_t     rs1_val;
    rv_isa_pkg::word_t     rs2_val;
    exec_pkg::wb_t         wb;

    // Source fields sit at fixed positions in every format.
    assign rs1_addr = issue_i.inst[19:15];
    assign rs2_addr = issue_i.inst[24:20];

    regfile regfile_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val),
        .wb_i       (wb)
    );

    arith arith_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .issue_i   (issue_i),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .wb_o      (wb)
    );

    assign wb_o = wb;

endmodule

/* logic/regfile.sv */
/* Integer register file, two combinational read ports and one write port.
 * x0 reads as zero; a pending write is forwarded to a matching read.
 */
`timescale 1ns/10ps

module regfile (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    output rv_isa_pkg::word_t     rs1_val_o,
    output rv_isa_pkg::word_t     rs2_val_o,
    input  exec_pkg::wb_t         wb_i
);
    rv_isa_pkg::word_t regs_q [1:31];  // x1 to x31.
    logic              wr_en;

    assign wr_en = wb_i.valid && !wb_i.illegal && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.value;
        end
    end

    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_val_o = '0;
        end else if (wr_en && (rs1_addr_i == wb_i.rd)) begin
            rs1_val_o = wb_i.value;  // Bypass.
        end else begin
            rs1_val_o = regs_q[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == '0) begin
            rs2_val_o = '0;
        end else if (wr_en && (rs2_addr_i == wb_i.rd)) begin
            rs2_val_o = wb_i.value;
        end else begin
            rs2_val_o = regs_q[rs2_addr_i];
        end
    end

endmodule

/* logic/rv_isa_pkg.sv */
/* ISA level types of RV32I: data words, register indices and instruction fields.
 * Referenced by scoped name from the execute slice and its testbench.
 */
package rv_isa_pkg;

    // Data or address word.
    typedef logic [31:0] word_t;

    // Index into the integer register file.
    typedef logic [4:0] reg_addr_t;

    // Raw 32-bit instruction as issued.
    typedef logic [31:0] inst_t;

    // Major opcode, bits 6:0 of the instruction.
    typedef logic [6:0] opcode_t;

    // Minor function code, bits 14:12.
    typedef logic [2:0] funct3_t;

    // Upper function code, bits 31:25.
    typedef logic [6:0] funct7_t;

endpackage

/* logic/rv_params.svh */
/* Widths, opcodes and function codes of the RV32I execute slice.
 * Include in any unit that decodes instructions or selects an ALU function.
 */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN       32
`define NUM_REGS   32
`define REG_AW     5

// Major opcodes handled by the slice.
`define OP_OP      7'b0110011
`define OP_OP_IMM  7'b0010011
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111

`define FUNCT3_ADD_SUB  3'b000
`define FUNCT3_SLL      3'b001
`define FUNCT3_SLT      3'b010
`define FUNCT3_SLTU     3'b011
`define FUNCT3_XOR      3'b100
`define FUNCT3_SR       3'b101  // SRL and SRA, split by funct7.
`define FUNCT3_OR       3'b110
`define FUNCT3_AND      3'b111

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000  // SUB and SRA.

`define ALU_OP_ADD      4'd0
`define ALU_OP_SUB      4'd1
`define ALU_OP_SLL      4'd2
`define ALU_OP_SLT      4'd3
`define ALU_OP_SLTU     4'd4
`define ALU_OP_XOR      4'd5
`define ALU_OP_SRL      4'd6
`define ALU_OP_SRA      4'd7
`define ALU_OP_OR       4'd8
`define ALU_OP_AND      4'd9
`define ALU_OP_PASS_B   4'd10  // Operand 2 straight through, for LUI.

`endif

/* run.sh */
#!/usr/bin/env bash
# Builds the execute slice testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module exec_tb -f flist.f
output=$(./obj_dir/Vexec_tb)
echo "$output"

if grep -qF "*** TEST PASSED ***" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* test/exec_tb.sv */
/* Directed testbench of the RV32I execute slice.
 * Issues instructions on the falling edge and checks each write-back against a register model.
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module exec_tb;
    // Roughly 5 reset + 32 + 88 + 55 + 26 + 30 + 50 cycles of tests.
    localparam int TEST_CYCLES    = 300;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

    localparam rv_isa_pkg::funct3_t RR_F3 [10] = '{`FUNCT3_ADD_SUB, `FUNCT3_ADD_SUB,
        `FUNCT3_SLL, `FUNCT3_SLT, `FUNCT3_SLTU, `FUNCT3_XOR, `FUNCT3_SR, `FUNCT3_SR,
        `FUNCT3_OR, `FUNCT3_AND};
    localparam rv_isa_pkg::funct7_t RR_F7 [10] = '{`FUNCT7_BASE, `FUNCT7_ALT,
        `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_ALT,
        `FUNCT7_BASE, `FUNCT7_BASE};
    localparam rv_isa_pkg::funct3_t IMM_F3 [9] = '{`FUNCT3_ADD_SUB, `FUNCT3_SLT,
        `FUNCT3_SLTU, `FUNCT3_XOR, `FUNCT3_OR, `FUNCT3_AND, `FUNCT3_SLL, `FUNCT3_SR,
        `FUNCT3_SR};
    localparam rv_isa_pkg::funct7_t IMM_F7 [9] = '{`FUNCT7_BASE, `FUNCT7_BASE,
        `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE, `FUNCT7_BASE,
        `FUNCT7_ALT};
    localparam int EDGE_A [4] = '{16, 17, 16, 18};  // x16 0x80000000, x17 all ones.
    localparam int EDGE_B [4] = '{17, 16, 18, 19};  // x18 0x7fffffff, x19 one.

    logic              clk_i = 1'b0;
    logic              arst_n_i;
    exec_pkg::issue_t  issue_i;
    exec_pkg::wb_t     wb_o;

    rv_isa_pkg::word_t model_regs [32];
    logic [31:0]       lfsr_state = 32'h91dd6454;
    int                cycle_count = 0;
    int                wb_errors = 0;
    int                word_errors = 0;
    int                flag_errors = 0;

    exec_top dut_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .issue_i  (issue_i),
        .wb_o     (wb_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: wb=%0d word=%0d flag=%0d", wb_errors, word_errors, flag_errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
    function automatic rv_isa_pkg::word_t rand_bits(input int n);
        rv_isa_pkg::word_t bits;
        logic              fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic rv_isa_pkg::reg_addr_t pick_reg(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return rv_isa_pkg::reg_addr_t'(lo + int'(rand_bits(8) % 32'(span)));
    endfunction

    function automatic rv_isa_pkg::inst_t enc_r(input rv_isa_pkg::funct7_t f7,
        input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1,
        input rv_isa_pkg::funct3_t f3, input rv_isa_pkg::reg_addr_t rd,
        input rv_isa_pkg::opcode_t opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm,
        input rv_isa_pkg::reg_addr_t rs1, input rv_isa_pkg::funct3_t f3,
        input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_isa_pkg::inst_t enc_u(input logic [19:0] imm,
        input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_isa_pkg::word_t read_model(input rv_isa_pkg::reg_addr_t idx);
        return (idx == '0) ? '0 : model_regs[idx];
    endfunction

    // RV32I integer result for one funct3, alt selects SUB and SRA.
    function automatic rv_isa_pkg::word_t rv32_op(input rv_isa_pkg::funct3_t f3,
        input logic alt, input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic exec_pkg::wb_t model_exec(input rv_isa_pkg::word_t pc,
        input rv_isa_pkg::inst_t inst);
        exec_pkg::wb_t       r;
        rv_isa_pkg::word_t   imm;
        rv_isa_pkg::funct3_t f3;
        rv_isa_pkg::funct7_t f7;
        f3 = inst[14:12];
        f7 = inst[31:25];
        imm = {{20{inst[31]}}, inst[31:20]};
        r = '{valid: 1'b1, illegal: 1'b0, rd: inst[11:7], value: '0};
        case (inst[6:0])
            `OP_OP: begin
                if (f7 == `FUNCT7_BASE || (f7 == `FUNCT7_ALT && (f3 == 3'b000 || f3 == 3'b101)))
                    r.value = rv32_op(f3, f7[5], read_model(inst[19:15]), read_model(inst[24:20]));
                else
                    r.illegal = 1'b1;
            end
            `OP_OP_IMM: begin
                if (f3 == 3'b001 && f7 != `FUNCT7_BASE)
                    r.illegal = 1'b1;
                else if (f3 == 3'b101 && f7 != `FUNCT7_BASE && f7 != `FUNCT7_ALT)
                    r.illegal = 1'b1;
                else
                    r.value = rv32_op(f3, f3 == 3'b101 && f7[5], read_model(inst[19:15]), imm);
            end
            `OP_LUI:            r.value = {inst[31:12], 12'b0};
            `OP_AUIPC:          r.value = pc + {inst[31:12], 12'b0};
            `OP_JAL, `OP_JALR:  r.value = pc + 32'd4;
            default:            r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    function automatic string wb_text(input exec_pkg::wb_t wb);
        return $sformatf("valid=%0b illegal=%0b rd=x%0d value=%08h",
                         wb.valid, wb.illegal, wb.rd, wb.value);
    endfunction

    task automatic check_wb(input string name, input exec_pkg::wb_t exp,
        input exec_pkg::wb_t act);
        if (act !== exp) begin
            wb_errors++;
            $display("mismatch %s: expected %s, actual %s", name, wb_text(exp), wb_text(act));
        end
    endtask

    task automatic check_word(input string name, input rv_isa_pkg::word_t exp,
        input rv_isa_pkg::word_t act);
        if (act !== exp) begin
            word_errors++;
            $display("mismatch %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // Called on a falling edge; the result is checked one falling edge later.
    task automatic issue(input string name, input rv_isa_pkg::word_t pc,
        input rv_isa_pkg::inst_t inst);
        exec_pkg::wb_t exp;
        exp = model_exec(pc, inst);
        if (!exp.illegal && exp.rd != '0) begin
            model_regs[exp.rd] = exp.value;
        end
        issue_i = '{valid: 1'b1, pc: pc, inst: inst};
        @(negedge clk_i);
        issue_i.valid = 1'b0;
        check_wb(name, exp, wb_o);
    endtask

    task automatic idle(input string name);
        issue_i.valid = 1'b0;
        @(negedge clk_i);
        check_flag(name, 1'b0, wb_o.valid);  // Single pulse per issue.
    endtask

    task automatic test_reset_load();
        rv_isa_pkg::reg_addr_t r;
        check_flag("reset_valid", 1'b0, wb_o.valid);
        check_flag("reset_illegal", 1'b0, wb_o.illegal);
        for (int i = 1; i < 16; i++) begin
            r = rv_isa_pkg::reg_addr_t'(i);
            issue("load_lui", 32'h0, enc_u(20'(rand_bits(20)), r, `OP_LUI));
            issue("load_addi", 32'h0,
                  enc_i(12'(rand_bits(12)), r, `FUNCT3_ADD_SUB, r, `OP_OP_IMM));
        end
        idle("load_idle");
    endtask

    task automatic test_reg_reg();
        rv_isa_pkg::reg_addr_t a;
        rv_isa_pkg::reg_addr_t b;
        issue("rr_setup", 32'h0, enc_u(20'h80000, 5'd16, `OP_LUI));
        issue("rr_setup", 32'h0, enc_i(12'hfff, 5'd0, `FUNCT3_ADD_SUB, 5'd17, `OP_OP_IMM));
        issue("rr_setup", 32'h0, enc_i(12'hfff, 5'd16, `FUNCT3_ADD_SUB, 5'd18, `OP_OP_IMM));
        issue("rr_setup", 32'h0, enc_i(12'h001, 5'd0, `FUNCT3_ADD_SUB, 5'd19, `OP_OP_IMM));
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 8; k++) begin
                if (k < 4) begin
                    a = rv_isa_pkg::reg_addr_t'(EDGE_A[k]);
                    b = rv_isa_pkg::reg_addr_t'(EDGE_B[k]);
                end else begin
                    a = pick_reg(1, 19);
                    b = pick_reg(1, 19);
                end
                issue($sformatf("reg_reg op %0d", op), 32'h0,
                      enc_r(RR_F7[op], b, a, RR_F3[op], pick_reg(20, 31), `OP_OP));
            end
        end
        idle("reg_reg_idle");
    endtask

    task automatic test_reg_imm();
        rv_isa_pkg::reg_addr_t a;
        logic [11:0]           imm;
        for (int op = 0; op < 9; op++) begin
            for (int k = 0; k < 6; k++) begin
                a = (k < 2) ? rv_isa_pkg::reg_addr_t'(16 + k) : pick_reg(1, 19);
                imm = (k == 0) ? 12'h800 : (k == 1) ? 12'hfff : 12'(rand_bits(12));
                if (IMM_F3[op] == `FUNCT3_SLL || IMM_F3[op] == `FUNCT3_SR) begin
                    imm = {IMM_F7[op], imm[4:0]};
                end
                issue($sformatf("reg_imm op %0d", op), 32'h0,
                      enc_i(imm, a, IMM_F3[op], pick_reg(20, 31), `OP_OP_IMM));
            end
        end
        idle("reg_imm_idle");
    endtask

    task automatic test_pc_link();
        rv_isa_pkg::word_t pc;
        for (int i = 0; i < 8; i++) begin
            pc = rand_bits(30) << 2;
            issue("auipc", pc, enc_u(20'(rand_bits(20)), pick_reg(1, 31), `OP_AUIPC));
            issue("jal", pc, enc_u(20'(rand_bits(20)), pick_reg(1, 31), `OP_JAL));
            check_word("jal_link", pc + 32'd4, wb_o.value);
            issue("jalr", pc, enc_i(12'(rand_bits(12)), pick_reg(1, 31), 3'b000,
                                    pick_reg(1, 31), `OP_JALR));
        end
        issue("jal_wrap", 32'hffff_fffc, enc_u(20'h0, 5'd1, `OP_JAL));
        idle("pc_link_idle");
    endtask

    task automatic test_dependency();
        rv_isa_pkg::reg_addr_t prev;
        rv_isa_pkg::reg_addr_t nxt;
        rv_isa_pkg::funct3_t   f3;
        rv_isa_pkg::funct7_t   f7;
        prev = 5'd1;
        issue("dep_start", 32'h0,
              enc_i(12'(rand_bits(12)), 5'd0, `FUNCT3_ADD_SUB, prev, `OP_OP_IMM));
        for (int i = 0; i < 24; i++) begin
            nxt = pick_reg(1, 31);
            f3 = 3'(rand_bits(3));
            f7 = `FUNCT7_BASE;
            if ((f3 == `FUNCT3_ADD_SUB || f3 == `FUNCT3_SR) && rand_bits(1) != '0) begin
                f7 = `FUNCT7_ALT;
            end
            issue("dep_chain", 32'h0,
                  enc_r(f7, (i % 2 == 0) ? prev : pick_reg(1, 31), prev, f3, nxt, `OP_OP));
            prev = nxt;
        end
        // x0 stays zero even with a write pending on the bypass.
        issue("x0_write", 32'h0, enc_i(12'h123, prev, `FUNCT3_ADD_SUB, 5'd0, `OP_OP_IMM));
        issue("x0_bypass", 32'h0, enc_r(`FUNCT7_BASE, prev, 5'd0, `FUNCT3_OR, 5'd21, `OP_OP));
        issue("x0_lui", 32'h0, enc_u(20'habcde, 5'd0, `OP_LUI));
        issue("x0_read", 32'h0, enc_r(`FUNCT7_BASE, 5'd0, 5'd0, `FUNCT3_OR, 5'd22, `OP_OP));
        check_word("x0_read", '0, wb_o.value);
        idle("dep_idle");
    endtask

    task automatic test_illegal();
        rv_isa_pkg::word_t     snap [32];
        rv_isa_pkg::inst_t     bad [8];
        rv_isa_pkg::reg_addr_t rd;
        snap = model_regs;
        bad[0] = enc_i(12'(rand_bits(12)), pick_reg(1, 31), 3'b010, 5'd0, 7'b0000011);
        bad[1] = enc_i(12'(rand_bits(12)), pick_reg(1, 31), 3'b010, 5'd0, 7'b0100011);
        bad[2] = enc_i(12'(rand_bits(12)), pick_reg(1, 31), 3'b000, 5'd0, 7'b1100011);
        bad[3] = enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'b1110011);
        bad[4] = enc_r(`FUNCT7_ALT, 5'd1, 5'd2, `FUNCT3_SLL, 5'd0, `OP_OP);
        bad[5] = enc_r(7'b0000001, 5'd3, 5'd4, `FUNCT3_ADD_SUB, 5'd0, `OP_OP);
        bad[6] = enc_i({`FUNCT7_ALT, 5'd3}, 5'd5, `FUNCT3_SLL, 5'd0, `OP_OP_IMM);
        bad[7] = enc_i({7'b0000001, 5'd7}, 5'd6, `FUNCT3_SR, 5'd0, `OP_OP_IMM);
        for (int i = 0; i < 8; i++) begin
            rd = pick_reg(1, 31);
            bad[i][11:7] = rd;
            issue($sformatf("illegal %0d", i), 32'h0, bad[i]);
            // The following read must not see the illegal result.
            issue("illegal_next", 32'h0, enc_i(12'h000, rd, `FUNCT3_ADD_SUB, rd, `OP_OP_IMM));
        end
        idle("illegal_idle");
        for (int k = 1; k < 32; k++) begin
            rd = rv_isa_pkg::reg_addr_t'(k);
            issue("illegal_readback", 32'h0,
                  enc_i(12'h000, rd, `FUNCT3_ADD_SUB, rd, `OP_OP_IMM));
            check_word("illegal_readback", snap[k], wb_o.value);
        end
        idle("readback_idle");
    endtask

    initial begin
        // An unhandled instruction stays offered while reset is held.
        issue_i = '{valid: 1'b1, pc: '0, inst: '0};
        arst_n_i = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;
        issue_i = '0;

        test_reset_load();
        test_reg_reg();
        test_reg_imm();
        test_pc_link();
        test_dependency();
        test_illegal();

        $display("errors: wb=%0d word=%0d flag=%0d", wb_errors, word_errors, flag_errors);
        if (wb_errors + word_errors + flag_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
